//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= icache_tb
LINT_TOP  ?= icache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SOURCES   := $(wildcard hdl/*.sv) $(wildcard sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || \
		(echo "no pass line found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  cpu_req_t              cpu_req,
    output cpu_rsp_t              cpu_rsp,
    output mem_req_t              mem_req,
    input  mem_rsp_t              mem_rsp,
    output logic [index_bits-1:0] lookup_index,
    input  line_lookup_t          lookup,
    output line_fill_t            fill,
    output logic                  flush_clear
);

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_allocate
    } state_t;

    state_t               state_q;
    state_t               state_next;
    icache_addr_u         req_addr_q;
    logic                 flush_pend_q;
    logic                 rsp_ready_q;
    logic [word_bits-1:0] rsp_data_q;
    logic                 mem_valid_q;
    logic [word_bits-1:0] mem_addr_q;
    logic                 hit;
    logic                 accept;
    logic                 mem_done;

    // ##################################################
    // decisions
    // ##################################################
    // flush is taken only in idle; a request seen in the same cycle waits
    assign flush_clear = (state_q == st_idle) && (flush || flush_pend_q);

    // skip the cycle where the fetch unit still holds valid beside our ready
    assign accept = (state_q == st_idle) && cpu_req.valid && !rsp_ready_q && !flush_clear;

    assign hit      = lookup.valid && (lookup.tag == req_addr_q.fields.tag);
    assign mem_done = (state_q == st_allocate) && mem_rsp.ready;

    always_comb
    begin
        state_next = state_q;
        case (state_q)
            st_idle:
            begin
                if (accept)
                begin
                    state_next = st_compare;
                end
            end
            st_compare:
            begin
                state_next = hit ? st_idle : st_allocate;
            end
            st_allocate:
            begin
                if (mem_rsp.ready)
                begin
                    state_next = st_compare;   // compare again, now a hit
                end
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    // ##################################################
    // control registers
    // ##################################################
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q      <= st_idle;
            flush_pend_q <= 1'b0;
            rsp_ready_q  <= 1'b0;
            mem_valid_q  <= 1'b0;
        end
        else
        begin
            state_q     <= state_next;
            rsp_ready_q <= (state_q == st_compare) && hit;   // single-cycle pulse
            if (flush_clear)
            begin
                flush_pend_q <= 1'b0;
            end
            else if (flush)
            begin
                flush_pend_q <= 1'b1;
            end
            if ((state_q == st_compare) && !hit)
            begin
                mem_valid_q <= 1'b1;
            end
            else if (mem_done)
            begin
                mem_valid_q <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr_q <= cpu_req.addr;
        end
        if ((state_q == st_compare) && hit)
        begin
            rsp_data_q <= lookup.data;
        end
        if ((state_q == st_compare) && !hit)
        begin
            mem_addr_q <= {req_addr_q.raw[word_bits-1:offset_bits], {offset_bits{1'b0}}};
        end
    end

    // ##################################################
    // outputs
    // ##################################################
    assign lookup_index = req_addr_q.fields.index;

    assign fill.we    = mem_done;   // written on the edge memory answers
    assign fill.index = req_addr_q.fields.index;
    assign fill.tag   = req_addr_q.fields.tag;
    assign fill.data  = mem_rsp.data;

    assign cpu_rsp.ready = rsp_ready_q;
    assign cpu_rsp.data  = rsp_data_q;
    assign mem_req.valid = mem_valid_q;
    assign mem_req.addr  = mem_addr_q;

endmodule

//--- hdl/icache_pkg.sv
package icache_pkg;

    // ##################################################
    // cache geometry
    // ##################################################
    localparam int line_count  = 16;
    localparam int index_bits  = 4;
    localparam int offset_bits = 2;
    localparam int tag_bits    = 26;
    localparam int word_bits   = 32;

    // ##################################################
    // address views
    // ##################################################
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;   // always zero for word fetches
    } icache_addr_fields_t;

    typedef union packed {
        logic [word_bits-1:0] raw;
        icache_addr_fields_t  fields;
    } icache_addr_u;

    // ##################################################
    // port and internal bundles
    // ##################################################
    typedef struct packed {
        logic         valid;
        icache_addr_u addr;
    } cpu_req_t;

    typedef struct packed {
        logic                 ready;   // one-cycle pulse
        logic [word_bits-1:0] data;
    } cpu_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic [word_bits-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                 ready;
        logic [word_bits-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_bits-1:0]  tag;
        logic [word_bits-1:0] data;
    } line_lookup_t;

    typedef struct packed {
        logic                  we;
        logic [index_bits-1:0] index;
        logic [tag_bits-1:0]   tag;
        logic [word_bits-1:0]  data;
    } line_fill_t;

endpackage

//--- hdl/icache_store.sv
`timescale 1ns/1ps

module icache_store
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_clear,
    input  logic [index_bits-1:0] lookup_index,
    input  line_fill_t            fill,
    output line_lookup_t          lookup
);

    // ##################################################
    // line storage
    // ##################################################
    logic [line_count-1:0] valid_q;
    logic [tag_bits-1:0]   tag_mem  [line_count];
    logic [word_bits-1:0]  data_mem [line_count];

    // reset and flush clear the valid bits
    always_ff @(posedge clk)
    begin
        if (rst || flush_clear)
        begin
            valid_q <= '0;
        end
        else if (fill.we)
        begin
            valid_q[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill.we)
        begin
            tag_mem[fill.index]  <= fill.tag;
            data_mem[fill.index] <= fill.data;
        end
    end

    // ##################################################
    // lookup of the indexed line
    // ##################################################
    always_comb
    begin
        lookup.valid = valid_q[lookup_index];
        lookup.tag   = tag_mem[lookup_index];
        lookup.data  = data_mem[lookup_index];
    end

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // ##################################################
    // controller to store
    // ##################################################
    logic [index_bits-1:0] lookup_index;
    line_lookup_t          lookup;
    line_fill_t            fill;
    logic                  flush_clear;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .lookup_index (lookup_index),
        .lookup       (lookup),
        .fill         (fill),
        .flush_clear  (flush_clear)
    );

    icache_store u_store (
        .clk          (clk),
        .rst          (rst),
        .flush_clear  (flush_clear),
        .lookup_index (lookup_index),
        .fill         (fill),
        .lookup       (lookup)
    );

endmodule

//--- sim/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
;

    localparam int timeout_cycles = 200;
    localparam int max_rows       = 80;
    localparam int random_rows    = 64;

    typedef enum logic [1:0] {
        op_fetch,       // expected miss flag from the table
        op_flush,
        op_fetch_ref    // expected miss taken from the reference model only
    } op_t;

    typedef struct packed {
        op_t                  op;
        logic [word_bits-1:0] addr;
        logic                 miss;
    } row_t;

    logic     clk;
    logic     rst;
    logic     flush;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    row_t                 stim [max_rows];
    int                   row_total;
    logic [31:0]          rng_state;
    logic [word_bits-1:0] cur_addr;
    int                   mem_req_count;
    int                   expected_total;
    int                   mem_delay;
    logic                 mem_prev_valid;
    logic [line_count-1:0] ref_valid;
    logic [tag_bits-1:0]   ref_tag [line_count];

    icache_top dut (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #4 clk = ~clk;

    // ##################################################
    // helpers
    // ##################################################
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents are the address xor a constant rotated left by 7
    function automatic logic [word_bits-1:0] mem_word(input logic [word_bits-1:0] addr);
        logic [word_bits-1:0] v;
        v = addr ^ 32'h5a3c_96e1;
        return {v[24:0], v[31:25]};
    endfunction

    function automatic logic predict_miss(input icache_addr_u a);
        return !ref_valid[a.fields.index] || (ref_tag[a.fields.index] != a.fields.tag);
    endfunction

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        stop_with_failure();
    endtask

    task automatic no_response();
        $display("no response from cache within %0d cycles at %0t", timeout_cycles, $time);
        stop_with_failure();
    endtask

    // ##################################################
    // compare tasks
    // ##################################################
    task automatic check_rsp(input cpu_rsp_t got, input logic exp_ready,
                             input logic [word_bits-1:0] exp_data);
        if (got.ready !== exp_ready)
            report_mismatch("cpu_rsp.ready", {31'b0, exp_ready}, {31'b0, got.ready});
        if (exp_ready && (got.data !== exp_data))
            report_mismatch("cpu_rsp.data", exp_data, got.data);
    endtask

    task automatic check_mem_req(input mem_req_t got, input logic exp_valid,
                                 input logic [word_bits-1:0] exp_addr);
        if (got.valid !== exp_valid)
            report_mismatch("mem_req.valid", {31'b0, exp_valid}, {31'b0, got.valid});
        if (exp_valid && (got.addr !== exp_addr))
            report_mismatch("mem_req.addr", exp_addr, got.addr);
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp)
            report_mismatch("mem_req_count", 32'(exp), 32'(got));
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp)
            report_mismatch("hit_latency", 32'(exp), 32'(got));
    endtask

    // ##################################################
    // memory model
    // ##################################################
    always
    begin
        @(posedge clk);
        #1;
        if (rst)
        begin
            mem_prev_valid = 1'b0;
            mem_delay      = 0;
        end
        else
        begin
            if (mem_req.valid && !mem_prev_valid)   // new request
            begin
                mem_req_count++;
                check_mem_req(mem_req, 1'b1, {cur_addr[word_bits-1:offset_bits], 2'b00});
                rng_state = xorshift32(rng_state);
                mem_delay = int'(rng_state % 4);
            end
            mem_prev_valid = mem_req.valid;
            if (mem_rsp.ready)
            begin
                mem_rsp = '0;   // ready lasts one cycle
            end
            else if (mem_req.valid)
            begin
                if (mem_delay == 0)
                begin
                    mem_rsp.ready = 1'b1;
                    mem_rsp.data  = mem_word(mem_req.addr);
                end
                else
                begin
                    mem_delay--;
                end
            end
        end
    end

    // ##################################################
    // stimulus
    // ##################################################
    task automatic add_row(input op_t op, input logic [word_bits-1:0] addr, input logic miss);
        stim[row_total] = '{op: op, addr: addr, miss: miss};
        row_total++;
    endtask

    task automatic build_table();
        icache_addr_u a;
        add_row(op_fetch, 32'h0000_1004, 1'b1);
        add_row(op_fetch, 32'h0000_1004, 1'b0);
        add_row(op_fetch, 32'h0000_1008, 1'b1);
        add_row(op_fetch, 32'h0000_1004, 1'b0);
        add_row(op_fetch, 32'h0000_2004, 1'b1);   // same index, new tag
        add_row(op_fetch, 32'h0000_1004, 1'b1);
        add_row(op_fetch, 32'h0000_2004, 1'b1);
        add_row(op_fetch, 32'h0000_1004, 1'b1);
        add_row(op_fetch, 32'h0000_1008, 1'b0);   // other index untouched
        add_row(op_flush, 32'h0000_0000, 1'b0);
        add_row(op_fetch, 32'h0000_1004, 1'b1);
        add_row(op_fetch, 32'h0000_1008, 1'b1);
        add_row(op_fetch, 32'h0000_1004, 1'b0);
        add_row(op_fetch, 32'h0000_1008, 1'b0);
        for (int i = 0; i < random_rows; i++)
        begin
            rng_state       = xorshift32(rng_state);
            a.raw           = '0;
            a.fields.tag    = 26'h100 + {24'b0, rng_state[1:0]};   // four tags only
            a.fields.index  = rng_state[7:4];
            add_row(op_fetch_ref, a.raw, 1'b0);
        end
    endtask

    task automatic do_fetch(input logic [word_bits-1:0] addr, input logic exp_miss);
        int edges;
        edges          = 0;
        cur_addr       = addr;
        cpu_req.valid  = 1'b1;
        cpu_req.addr   = addr;
        do
        begin
            @(posedge clk);
            #1;
            edges++;
        end while ((cpu_rsp.ready !== 1'b1) && (edges < timeout_cycles));
        if (cpu_rsp.ready !== 1'b1)
            no_response();
        check_rsp(cpu_rsp, 1'b1, mem_word(addr));
        if (!exp_miss)
            check_latency(edges, 2);
        cpu_req.valid = 1'b0;
        @(posedge clk);
        #1;
        check_rsp(cpu_rsp, 1'b0, '0);   // ready was a single pulse
    endtask

    task automatic do_flush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush     = 1'b0;
        ref_valid = '0;
    endtask

    task automatic apply_row(input int i);
        icache_addr_u a;
        logic         exp_miss;
        int           count_before;
        a = stim[i].addr;
        if (stim[i].op == op_flush)
        begin
            do_flush();
        end
        else
        begin
            exp_miss = predict_miss(a);
            if ((stim[i].op == op_fetch) && (stim[i].miss != exp_miss))
            begin
                $display("table row %0d disagrees with the reference model on hit or miss", i);
                stop_with_failure();
            end
            count_before = mem_req_count;
            do_fetch(a.raw, exp_miss);
            check_count(mem_req_count, count_before + (exp_miss ? 1 : 0));
            if (exp_miss)
                expected_total++;
            ref_valid[a.fields.index] = 1'b1;
            ref_tag[a.fields.index]   = a.fields.tag;
        end
    endtask

    initial
    begin
        clk            = 1'b0;
        rst            = 1'b1;
        flush          = 1'b0;
        cpu_req        = '0;
        mem_rsp        = '0;
        rng_state      = 32'h99ac;
        cur_addr       = '0;
        mem_req_count  = 0;
        expected_total = 0;
        row_total      = 0;
        ref_valid      = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_rsp(cpu_rsp, 1'b0, '0);
        check_mem_req(mem_req, 1'b0, '0);
        for (int i = 0; i < row_total; i++)
            apply_row(i);
        check_count(mem_req_count, expected_total);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- vlog.f
hdl/icache_pkg.sv
hdl/icache_store.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/icache_tb.sv
